//--- hdl/game_pkg.sv
`default_nettype none

package game_pkg;

    typedef enum logic [1:0] {
        PH_IDLE  = 2'd0,
        PH_MOVE  = 2'd1,
        PH_TRAIL = 2'd2
    } phase_t;

    // Direction the head faces
    typedef enum logic [1:0] {
        HD_RIGHT = 2'd0,
        HD_LEFT  = 2'd1,
        HD_UP    = 2'd2,
        HD_DOWN  = 2'd3
    } heading_t;

    typedef enum logic [2:0] {
        SEG_A = 3'd0,
        SEG_B = 3'd1,
        SEG_C = 3'd2,
        SEG_D = 3'd3,
        SEG_E = 3'd4,
        SEG_F = 3'd5,
        SEG_G = 3'd6
    } seg_idx_t;

    // Phase lengths in ticks
    localparam int IDLE_SECONDS     = 3;
    localparam int TRAIL_HOLD_TICKS = 1;

    localparam int DEBOUNCE_SAMPLES = 4;

    // Board defaults for a 100 MHz clock
    localparam int DEF_SAMPLE_DIV = 100_000;
    localparam int DEF_SECOND_DIV = 100_000_000;

endpackage

`default_nettype wire

//--- hdl/seg_pkg.sv
`default_nettype none

package seg_pkg;

    // Active-low word where bit i drives segment i (a is bit 0)
    typedef logic [6:0] seg_word_t;

    localparam seg_word_t SEG_ALL_OFF = 7'b111_1111;
    localparam seg_word_t SEG_ALL_ON  = 7'b000_0000;

    // Word with a single segment lit
    function automatic seg_word_t seg_pattern(input game_pkg::seg_idx_t idx);
        seg_word_t word;
        word = SEG_ALL_OFF;
        word[idx] = 1'b0;
        return word;
    endfunction

endpackage

`default_nettype wire

//--- hdl/tick_gen.sv
`default_nettype none

module tick_gen #(
    parameter int DIV = 4
) (
    input  wire  clk,
    input  wire  rst,
    output logic tick
);

    localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [CW-1:0] LAST = CW'(DIV - 1);

    logic [CW-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt == LAST) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // One clock wide enable on the wrap
    assign tick = (cnt == LAST);

endmodule

`default_nettype wire

//--- hdl/button_cond.sv
`default_nettype none

module button_cond (
    input  wire  clk,
    input  wire  rst,
    input  wire  sample_tick,
    input  wire  btn,
    output logic press
);

    import game_pkg::*;

    logic [DEBOUNCE_SAMPLES-1:0] samples;
    logic                        stable;
    logic                        stable_d;

    // One sample per sample tick
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samples <= '0;
        end else if (sample_tick) begin
            samples <= {samples[DEBOUNCE_SAMPLES-2:0], btn};
        end
    end

    assign stable = &samples;

    // Rising edge of the debounced level
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stable_d <= 1'b0;
            press    <= 1'b0;
        end else begin
            stable_d <= stable;
            press    <= stable & ~stable_d;
        end
    end

endmodule

`default_nettype wire

//--- hdl/path_nav.sv
`default_nettype none

module path_nav (
    input  wire                clk,
    input  wire                rst,
    input  game_pkg::phase_t   phase,
    input  wire                restart,
    input  wire                right_press,
    input  wire                left_press,
    input  wire                up_press,
    output game_pkg::seg_idx_t pos,
    output game_pkg::heading_t head
);

    import game_pkg::*;

    seg_idx_t nxt_pos;
    heading_t nxt_head;
    logic     active;

    assign active = (phase == PH_MOVE) || (phase == PH_TRAIL);

    // Navigation table where unmatched presses keep pos and head
    always_comb begin
        nxt_pos  = pos;
        nxt_head = head;
        case (pos)
            SEG_A: begin
                if (head == HD_RIGHT && right_press) begin
                    nxt_pos  = SEG_B;
                    nxt_head = HD_DOWN;
                end else if (head == HD_LEFT && left_press) begin
                    nxt_pos  = SEG_F;
                    nxt_head = HD_DOWN;
                end
            end
            SEG_B: begin
                if (head == HD_UP && left_press) begin
                    nxt_pos  = SEG_A;
                    nxt_head = HD_LEFT;
                end else if (head == HD_DOWN && right_press) begin
                    nxt_pos  = SEG_G;
                    nxt_head = HD_LEFT;
                end else if (head == HD_DOWN && up_press) begin
                    nxt_pos  = SEG_C;
                    nxt_head = HD_DOWN;
                end
            end
            SEG_C: begin
                if (head == HD_UP && left_press) begin
                    nxt_pos  = SEG_G;
                    nxt_head = HD_LEFT;
                end else if (head == HD_UP && up_press) begin
                    nxt_pos  = SEG_B;
                    nxt_head = HD_UP;
                end else if (head == HD_DOWN && right_press) begin
                    nxt_pos  = SEG_D;
                    nxt_head = HD_DOWN;
                end
            end
            SEG_D: begin
                if (head == HD_RIGHT && left_press) begin
                    nxt_pos  = SEG_C;
                    nxt_head = HD_UP;
                end else if (head == HD_LEFT && right_press) begin
                    nxt_pos  = SEG_E;
                    nxt_head = HD_UP;
                end
            end
            SEG_E: begin
                if (head == HD_UP && right_press) begin
                    nxt_pos  = SEG_G;
                    nxt_head = HD_RIGHT;
                end else if (head == HD_UP && up_press) begin
                    nxt_pos  = SEG_F;
                    nxt_head = HD_UP;
                end else if (head == HD_DOWN && left_press) begin
                    nxt_pos  = SEG_D;
                    nxt_head = HD_RIGHT;
                end
            end
            SEG_F: begin
                if (head == HD_UP && right_press) begin
                    nxt_pos  = SEG_A;
                    nxt_head = HD_RIGHT;
                end else if (head == HD_DOWN && left_press) begin
                    nxt_pos  = SEG_G;
                    nxt_head = HD_RIGHT;
                end
            end
            SEG_G: begin
                if (head == HD_RIGHT && left_press) begin
                    nxt_pos  = SEG_B;
                    nxt_head = HD_UP;
                end else if (head == HD_RIGHT && right_press) begin
                    nxt_pos  = SEG_C;
                    nxt_head = HD_DOWN;
                end else if (head == HD_LEFT && left_press) begin
                    nxt_pos  = SEG_E;
                    nxt_head = HD_DOWN;
                end else if (head == HD_LEFT && right_press) begin
                    nxt_pos  = SEG_F;
                    nxt_head = HD_UP;
                end
            end
            default: begin
                nxt_pos  = SEG_G;
                nxt_head = HD_LEFT;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos  <= SEG_G;
            head <= HD_LEFT;
        end else if (restart) begin
            pos  <= SEG_G;
            head <= HD_LEFT;
        end else if (active) begin
            pos  <= nxt_pos;
            head <= nxt_head;
        end
    end

endmodule

`default_nettype wire

//--- hdl/game_ctrl.sv
`default_nettype none

module game_ctrl (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 second_tick,
    input  wire                 half_tick,
    input  wire                 down_press,
    input  game_pkg::seg_idx_t  pos,
    output game_pkg::phase_t    phase,
    output logic                restart,
    output seg_pkg::seg_word_t  trail,
    output logic                init,
    output logic                move,
    output logic                fall
);

    import game_pkg::*;
    import seg_pkg::*;

    localparam int SEC_W  = $clog2(IDLE_SECONDS + 1);
    localparam int HOLD_W = (TRAIL_HOLD_TICKS > 1) ? $clog2(TRAIL_HOLD_TICKS) : 1;

    logic [SEC_W-1:0]  sec_cnt;
    logic [HOLD_W-1:0] hold_cnt;
    logic              trail_full;

    assign trail_full = (trail == SEG_ALL_ON);

    // Last half tick of the hold after a full trail
    assign restart = (phase == PH_TRAIL) && trail_full && half_tick &&
                     (hold_cnt == HOLD_W'(TRAIL_HOLD_TICKS - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase    <= PH_IDLE;
            sec_cnt  <= '0;
            hold_cnt <= '0;
            trail    <= SEG_ALL_OFF;
        end else begin
            case (phase)
                PH_IDLE: begin
                    // Leave one clock after the last second tick
                    if (sec_cnt == SEC_W'(IDLE_SECONDS)) begin
                        phase   <= PH_MOVE;
                        sec_cnt <= '0;
                    end else if (second_tick) begin
                        sec_cnt <= sec_cnt + 1'b1;
                    end
                end
                PH_MOVE: begin
                    if (down_press) begin
                        phase    <= PH_TRAIL;
                        trail    <= SEG_ALL_OFF;
                        hold_cnt <= '0;
                    end
                end
                PH_TRAIL: begin
                    trail[pos] <= 1'b0;
                    if (restart) begin
                        phase <= PH_IDLE;
                    end else if (trail_full && half_tick) begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    assign init = (phase == PH_IDLE);
    assign move = (phase == PH_MOVE);
    assign fall = (phase == PH_TRAIL);

endmodule

`default_nettype wire

//--- hdl/seg_render.sv
`default_nettype none

module seg_render (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 half_tick,
    input  game_pkg::phase_t    phase,
    input  game_pkg::seg_idx_t  pos,
    input  seg_pkg::seg_word_t  trail,
    output seg_pkg::seg_word_t  seg
);

    import game_pkg::*;
    import seg_pkg::*;

    logic blink;

    // Blink starts low on every trail entry
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blink <= 1'b0;
        end else if (phase != PH_TRAIL) begin
            blink <= 1'b0;
        end else if (half_tick) begin
            blink <= ~blink;
        end
    end

    always_comb begin
        seg = seg_pattern(pos);
        if (phase == PH_TRAIL) begin
            seg = trail;
            // Current segment flips while blink is high
            if (blink) begin
                seg[pos] = ~trail[pos];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/snake_seg_top.sv
`default_nettype none

module snake_seg_top #(
    parameter int SAMPLE_DIV = game_pkg::DEF_SAMPLE_DIV,
    parameter int SECOND_DIV = game_pkg::DEF_SECOND_DIV
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 right,
    input  wire                 left,
    input  wire                 up,
    input  wire                 down,
    output seg_pkg::seg_word_t  seg,
    output logic                init,
    output logic                move,
    output logic                fall,
    output game_pkg::heading_t  head,
    output game_pkg::seg_idx_t  pos
);

    import game_pkg::*;
    import seg_pkg::*;

    localparam int HALF_DIV = SECOND_DIV / 2;

    logic      sample_tick;
    logic      second_tick;
    logic      half_tick;
    logic      right_press;
    logic      left_press;
    logic      up_press;
    logic      down_press;
    logic      restart;
    phase_t    phase;
    seg_word_t trail;

    tick_gen #(.DIV(SAMPLE_DIV)) u_sample_tick (.clk(clk), .rst(rst), .tick(sample_tick));
    tick_gen #(.DIV(SECOND_DIV)) u_second_tick (.clk(clk), .rst(rst), .tick(second_tick));
    tick_gen #(.DIV(HALF_DIV))   u_half_tick   (.clk(clk), .rst(rst), .tick(half_tick));

    button_cond u_btn_right (
        .clk(clk), .rst(rst), .sample_tick(sample_tick), .btn(right), .press(right_press)
    );
    button_cond u_btn_left (
        .clk(clk), .rst(rst), .sample_tick(sample_tick), .btn(left), .press(left_press)
    );
    button_cond u_btn_up (
        .clk(clk), .rst(rst), .sample_tick(sample_tick), .btn(up), .press(up_press)
    );
    button_cond u_btn_down (
        .clk(clk), .rst(rst), .sample_tick(sample_tick), .btn(down), .press(down_press)
    );

    game_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .second_tick(second_tick),
        .half_tick  (half_tick),
        .down_press (down_press),
        .pos        (pos),
        .phase      (phase),
        .restart    (restart),
        .trail      (trail),
        .init       (init),
        .move       (move),
        .fall       (fall)
    );

    path_nav u_nav (
        .clk        (clk),
        .rst        (rst),
        .phase      (phase),
        .restart    (restart),
        .right_press(right_press),
        .left_press (left_press),
        .up_press   (up_press),
        .pos        (pos),
        .head       (head)
    );

    seg_render u_render (
        .clk      (clk),
        .rst      (rst),
        .half_tick(half_tick),
        .phase    (phase),
        .pos      (pos),
        .trail    (trail),
        .seg      (seg)
    );

endmodule

`default_nettype wire

//--- dv/tb_checker.sv
`default_nettype none

module tb_checker (
    input wire                clk,
    input seg_pkg::seg_word_t seg,
    input wire                init,
    input wire                move,
    input wire                fall,
    input game_pkg::heading_t head,
    input game_pkg::seg_idx_t pos
);

    timeunit 1ns;
    timeprecision 100ps;

    import game_pkg::*;

    int         checks = 0;
    int         fails = 0;
    logic [6:0] visited = '0;

    // Active-low word with one segment lit
    function automatic logic [6:0] one_lit(input int idx);
        return 7'h7f & ~(7'h01 << idx);
    endfunction

    task automatic check_val(input string label, input string sig,
                             input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (exp !== got) begin
            fails++;
            $display("Fail %s exp %h got %h (%s)", sig, exp, got, label);
        end
    endtask

    task automatic report_fail(input string msg);
        checks++;
        fails++;
        $display("Error: %s", msg);
    endtask

    // Position, heading, phase flags and, outside trail, the segment word
    task automatic check_step(input string label, input seg_idx_t exp_pos,
                              input heading_t exp_head, input phase_t exp_ph);
        int start;
        start = fails;
        check_val(label, "pos", 32'(exp_pos), 32'(pos));
        check_val(label, "head", 32'(exp_head), 32'(head));
        check_val(label, "init", 32'(exp_ph == PH_IDLE), 32'(init));
        check_val(label, "move", 32'(exp_ph == PH_MOVE), 32'(move));
        check_val(label, "fall", 32'(exp_ph == PH_TRAIL), 32'(fall));
        if (exp_ph != PH_TRAIL) begin
            check_val(label, "seg", 32'(one_lit(int'(exp_pos))), 32'(seg));
        end
        if (fails == start) begin
            $display("ok %s", label);
        end
    endtask

    // Visited segments stay lit while the head walks
    always @(negedge clk) begin
        if (fall) begin
            visited[pos] = 1'b1;
            for (int i = 0; i < 7; i++) begin
                if (visited[i] && i != int'(pos) && seg[i] !== 1'b0) begin
                    fails++;
                    $display("Fail seg[%0d] exp %h got %h", i, 1'b0, seg[i]);
                end
            end
        end else begin
            visited = '0;
        end
    end

    task automatic report_counts();
        $display("checks %0d failures %0d", checks, fails);
    endtask

endmodule

`default_nettype wire

//--- dv/tb_top.sv
`default_nettype none

module tb_top;

    timeunit 1ns;
    timeprecision 100ps;

    import game_pkg::*;
    import seg_pkg::*;

    localparam int SAMPLE_DIV = 4;
    localparam int SECOND_DIV = 64;
    localparam int HOLD = 6 * SAMPLE_DIV;
    localparam int NROWS = 33;
    localparam longint WATCHDOG_NS = (NROWS * 12 * SAMPLE_DIV + 10 * SECOND_DIV) * 10;

    // Row kinds and buttons
    localparam int K_PRESS = 0;
    localparam int K_SHORT = 1;
    localparam int K_LAST = 2;
    localparam int K_IDLE = 3;
    localparam int B_R = 0;
    localparam int B_L = 1;
    localparam int B_U = 2;
    localparam int B_D = 3;

    typedef struct {
        int       kind;
        int       btn;
        seg_idx_t pos;
        heading_t head;
    } row_t;

    logic      clk;
    logic      rst;
    logic      right;
    logic      left;
    logic      up;
    logic      down;
    seg_word_t seg;
    logic      init;
    logic      move;
    logic      fall;
    heading_t  head;
    seg_idx_t  pos;

    // Move walk, trail walk to completion, then a second move walk
    row_t rows [NROWS] = '{
        '{K_PRESS, B_R, SEG_F, HD_UP},    '{K_PRESS, B_R, SEG_A, HD_RIGHT},
        '{K_PRESS, B_R, SEG_B, HD_DOWN},  '{K_PRESS, B_R, SEG_G, HD_LEFT},
        '{K_PRESS, B_L, SEG_E, HD_DOWN},  '{K_PRESS, B_L, SEG_D, HD_RIGHT},
        '{K_PRESS, B_L, SEG_C, HD_UP},    '{K_PRESS, B_L, SEG_G, HD_LEFT},
        '{K_PRESS, B_U, SEG_G, HD_LEFT},  '{K_SHORT, B_L, SEG_G, HD_LEFT},
        '{K_PRESS, B_D, SEG_G, HD_LEFT},  '{K_PRESS, B_L, SEG_E, HD_DOWN},
        '{K_PRESS, B_L, SEG_D, HD_RIGHT}, '{K_PRESS, B_L, SEG_C, HD_UP},
        '{K_PRESS, B_U, SEG_B, HD_UP},    '{K_PRESS, B_L, SEG_A, HD_LEFT},
        '{K_LAST,  B_L, SEG_F, HD_DOWN},  '{K_IDLE,  B_R, SEG_G, HD_LEFT},
        '{K_PRESS, B_L, SEG_E, HD_DOWN},  '{K_PRESS, B_L, SEG_D, HD_RIGHT},
        '{K_PRESS, B_L, SEG_C, HD_UP},    '{K_PRESS, B_U, SEG_B, HD_UP},
        '{K_PRESS, B_L, SEG_A, HD_LEFT},  '{K_PRESS, B_L, SEG_F, HD_DOWN},
        '{K_PRESS, B_L, SEG_G, HD_RIGHT}, '{K_PRESS, B_L, SEG_B, HD_UP},
        '{K_PRESS, B_L, SEG_A, HD_LEFT},  '{K_PRESS, B_L, SEG_F, HD_DOWN},
        '{K_PRESS, B_R, SEG_F, HD_DOWN},  '{K_PRESS, B_L, SEG_G, HD_RIGHT},
        '{K_PRESS, B_R, SEG_C, HD_DOWN},  '{K_PRESS, B_R, SEG_D, HD_DOWN},
        '{K_PRESS, B_L, SEG_D, HD_DOWN}
    };

    snake_seg_top #(.SAMPLE_DIV(SAMPLE_DIV), .SECOND_DIV(SECOND_DIV)) DUT (
        .clk(clk), .rst(rst), .right(right), .left(left), .up(up), .down(down),
        .seg(seg), .init(init), .move(move), .fall(fall), .head(head), .pos(pos)
    );

    tb_checker u_chk (
        .clk(clk), .seg(seg), .init(init), .move(move), .fall(fall), .head(head), .pos(pos)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Error: watchdog expired before the last row finished");
        $display("TEST FAIL");
        $finish;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic set_btn(input int b, input logic v);
        case (b)
            B_R: right = v;
            B_L: left = v;
            B_U: up = v;
            default: down = v;
        endcase
    endtask

    task automatic wait_move(input string label);
        int n;
        n = 0;
        while (!move && n < 4 * SECOND_DIV) begin
            step();
            n++;
        end
        if (!move) begin
            u_chk.report_fail({label, ": move never rose after idle"});
        end
        u_chk.check_step(label, SEG_G, HD_LEFT, PH_MOVE);
    endtask

    initial begin
        int       n;
        int       hold;
        string    label;
        seg_idx_t p0;
        heading_t h0;
        phase_t   exp_ph;
        void'($urandom(32'hb31f_a105));
        rst = 1'b1;
        right = 1'b0;
        left = 1'b0;
        up = 1'b0;
        down = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        u_chk.check_step("reset", SEG_G, HD_LEFT, PH_IDLE);

        n = 0;
        while (!move && n < 4 * SECOND_DIV) begin
            step();
            n++;
        end
        u_chk.check_val("idle length", "move_delay", 32'(3 * SECOND_DIV + 1), 32'(n));
        u_chk.check_step("idle end", SEG_G, HD_LEFT, PH_MOVE);
        exp_ph = PH_MOVE;

        for (int i = 0; i < NROWS; i++) begin
            label = $sformatf("row %0d", i);
            if (rows[i].kind == K_IDLE) begin
                wait_move(label);
                exp_ph = PH_MOVE;
                continue;
            end
            // A short press gives three high samples, one short of a press
            hold = (rows[i].kind == K_SHORT) ? 3 * SAMPLE_DIV : HOLD;
            p0 = pos;
            h0 = head;
            set_btn(rows[i].btn, 1'b1);
            n = 0;
            while (n < hold && pos == p0 && head == h0) begin
                step();
                n++;
            end
            if (rows[i].btn == B_D) begin
                exp_ph = PH_TRAIL;
            end
            u_chk.check_step(label, rows[i].pos, rows[i].head, exp_ph);
            if (rows[i].kind == K_LAST) begin
                n = 0;
                while (!init && n < SECOND_DIV) begin
                    step();
                    n++;
                end
                if (n > SECOND_DIV / 2 + 2) begin
                    u_chk.report_fail({label, ": init did not rise after a full trail"});
                end
                u_chk.check_step({label, " restart"}, SEG_G, HD_LEFT, PH_IDLE);
                exp_ph = PH_IDLE;
            end
            while (n < hold) begin
                step();
                n++;
            end
            set_btn(rows[i].btn, 1'b0);
            repeat (HOLD) step();
            if (rows[i].kind == K_SHORT) begin
                u_chk.check_step({label, " after release"}, rows[i].pos, rows[i].head,
                                 exp_ph);
            end
            repeat ($urandom_range(3)) step();
        end

        u_chk.report_counts();
        if (u_chk.fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hdl/game_pkg.sv
hdl/seg_pkg.sv
hdl/tick_gen.sv
hdl/button_cond.sv
hdl/path_nav.sv
hdl/game_ctrl.sv
hdl/seg_render.sv
hdl/snake_seg_top.sv
dv/tb_checker.sv
dv/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_top -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "No result line in sim.log"
    exit 1
fi
exit 0
